/* hw/bop_pkg.sv */
// --------------------
// Shared widths, types and enums for the best-offset prefetcher
// Configuration struct carried from the register block
// --------------------

package bop_pkg;

  // Block address, byte offset already stripped
  parameter int BLK_ADDR_W = 26;
  typedef logic [BLK_ADDR_W-1:0] blk_addr_t;

  // Candidate offsets run 1 to 2**LG_OFFSETS-1
  parameter int LG_OFFSETS = 4;
  typedef logic [LG_OFFSETS-1:0] offset_t;

  parameter int SCORE_W = 4;
  typedef logic [SCORE_W-1:0] score_t;

  // 4 KiB page of 64-byte blocks
  parameter int PAGE_BLK_BITS = 6;

  // Fallback offset when no candidate wins a round set
  parameter offset_t INIT_OFFSET = offset_t'(1);

  typedef enum logic {
    CFG_ENABLE,
    CFG_MIN_SCORE
  } cfg_sel_e;

  typedef struct packed {
    logic   enable;
    score_t min_score;
  } cfg_t;

  typedef enum logic {
    S_IDLE,
    S_TEST
  } scorer_state_e;

endpackage

/* hw/bop_config_regs.sv */
// --------------------
// Prefetch enable and minimum-score registers
// --------------------

`timescale 1ns/100ps

module bop_config_regs (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cfg_we_i,
  input  bop_pkg::cfg_sel_e  cfg_sel_i,
  input  bop_pkg::score_t    cfg_data_i,
  output bop_pkg::cfg_t      cfg_o
);

  bop_pkg::cfg_t cfg_r;

  // Prefetching starts disabled, a score above 1 is needed by default
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_r.enable    <= 1'b0;
      cfg_r.min_score <= bop_pkg::score_t'(1);
    end else if (cfg_we_i) begin
      if (cfg_sel_i == bop_pkg::CFG_ENABLE) begin
        // Enable lives in bit 0 of the write data
        cfg_r.enable <= cfg_data_i[0];
      end else begin
        cfg_r.min_score <= cfg_data_i;
      end
    end
  end

  assign cfg_o = cfg_r;

endmodule

/* hw/bop_miss_queue.sv */
// --------------------
// Two-entry FIFO of miss block addresses
// Head is held until the scorer pops it
// --------------------

`timescale 1ns/100ps

module bop_miss_queue (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                push_i,
  input  bop_pkg::blk_addr_t  push_addr_i,
  output logic                ready_o,
  output logic                head_v_o,
  output bop_pkg::blk_addr_t  head_addr_o,
  input  logic                pop_i
);

  bop_pkg::blk_addr_t mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  assign ready_o     = (count_r != 2'd2);
  assign head_v_o    = (count_r != 2'd0);
  assign head_addr_o = mem_r[rd_ptr_r];

  assign push = push_i & ready_o;
  assign pop  = pop_i & head_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) wr_ptr_r <= ~wr_ptr_r;
      if (pop) rd_ptr_r <= ~rd_ptr_r;
      // Push and pop together leave the count alone
      if (push && !pop) count_r <= count_r + 2'd1;
      else if (pop && !push) count_r <= count_r - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= push_addr_i;
  end

endmodule

/* hw/bop_history_cam.sv */
// --------------------
// History of recently filled prefetch addresses
// Associative match lookup, empty-first round-robin replacement
// --------------------

`timescale 1ns/100ps

module bop_history_cam #(
  parameter int history_len_p = 8
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fill_v_i,
  input  bop_pkg::blk_addr_t  fill_addr_i,
  input  logic                test_v_i,
  input  bop_pkg::blk_addr_t  test_addr_i,
  output logic                match_o
);

  localparam int idx_w_lp = (history_len_p > 1) ? $clog2(history_len_p) : 1;

  bop_pkg::blk_addr_t     tag_r [history_len_p];
  logic [history_len_p-1:0] valid_r;
  logic [idx_w_lp-1:0]    victim_r;
  logic [idx_w_lp-1:0]    empty_idx;
  logic [idx_w_lp-1:0]    wr_idx;
  logic                   empty_found;
  logic                   hit_any;

  // Lowest-numbered empty entry
  always_comb begin
    empty_found = 1'b0;
    empty_idx   = '0;
    for (int i = history_len_p - 1; i >= 0; i--) begin
      if (!valid_r[i]) begin
        empty_found = 1'b1;
        empty_idx   = idx_w_lp'(i);
      end
    end
  end

  assign wr_idx = empty_found ? empty_idx : victim_r;

  // Lookup sees the contents from before a same-cycle fill
  always_comb begin
    hit_any = 1'b0;
    for (int i = 0; i < history_len_p; i++) begin
      hit_any = hit_any | (valid_r[i] && (tag_r[i] == test_addr_i));
    end
  end

  assign match_o = test_v_i & hit_any;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
    end else if (fill_v_i) begin
      valid_r[wr_idx] <= 1'b1;
      // Entries fill in order, so the victim pointer tracks the oldest
      if (!empty_found) begin
        if (victim_r == idx_w_lp'(history_len_p - 1)) victim_r <= '0;
        else victim_r <= victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) tag_r[wr_idx] <= fill_addr_i;
  end

endmodule

/* hw/bop_offset_scorer.sv */
// --------------------
// Per-offset score table and round state machine
// Tests one candidate offset per cycle, holds the best offset
// --------------------

`timescale 1ns/100ps

module bop_offset_scorer #(
  parameter int max_score_p  = 4,
  parameter int max_rounds_p = 3
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                head_v_i,
  input  bop_pkg::blk_addr_t  head_addr_i,
  output logic                pop_o,
  output logic                test_v_o,
  output bop_pkg::blk_addr_t  test_addr_o,
  input  logic                match_i,
  input  bop_pkg::cfg_t       cfg_i,
  output bop_pkg::offset_t    offset_o
);

  localparam int round_w_lp = $clog2(max_rounds_p + 1);
  localparam int num_offsets_lp = 2 ** bop_pkg::LG_OFFSETS;
  localparam bop_pkg::offset_t first_offset_lp = bop_pkg::offset_t'(1);
  localparam bop_pkg::offset_t last_offset_lp = '1;

  bop_pkg::scorer_state_e state_r, state_n;
  bop_pkg::offset_t       test_offset_r, test_offset_n;
  bop_pkg::score_t        scores_r [1:num_offsets_lp-1];
  bop_pkg::offset_t       leader_r, leader_n;
  bop_pkg::score_t        leader_score_r, leader_score_n;
  logic [round_w_lp-1:0]  round_r;
  bop_pkg::offset_t       best_r;
  bop_pkg::score_t        score_inc;
  logic                   hit;
  logic                   win;
  logic                   last_test;
  logic                   round_end;

  // Score the head miss against the history at miss plus candidate
  assign test_v_o    = head_v_i;
  assign test_addr_o = head_addr_i + bop_pkg::blk_addr_t'(test_offset_r);

  assign last_test = test_v_o && (test_offset_r == last_offset_lp);
  assign pop_o     = last_test && (state_r == bop_pkg::S_TEST);

  assign hit       = test_v_o & match_i;
  assign score_inc = scores_r[test_offset_r] + 1'b1;
  assign win       = hit && (score_inc == bop_pkg::score_t'(max_score_p));
  assign round_end = pop_o && (round_r == round_w_lp'(max_rounds_p - 1));

  // Strictly higher score takes the lead, ties keep the lower offset
  always_comb begin
    leader_n       = leader_r;
    leader_score_n = leader_score_r;
    if (hit && (score_inc > leader_score_r)) begin
      leader_n       = test_offset_r;
      leader_score_n = score_inc;
    end
  end

  // Offset 1 is tested on arrival, 2 to 15 follow in S_TEST
  always_comb begin
    state_n       = state_r;
    test_offset_n = test_offset_r;
    case (state_r)
      bop_pkg::S_IDLE: begin
        if (head_v_i) begin
          state_n       = bop_pkg::S_TEST;
          test_offset_n = test_offset_r + 1'b1;
        end
      end
      bop_pkg::S_TEST: begin
        if (last_test) begin
          state_n       = bop_pkg::S_IDLE;
          test_offset_n = first_offset_lp;
        end else if (head_v_i) begin
          test_offset_n = test_offset_r + 1'b1;
        end
      end
      default: begin
        state_n       = bop_pkg::S_IDLE;
        test_offset_n = first_offset_lp;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r        <= bop_pkg::S_IDLE;
      test_offset_r  <= first_offset_lp;
      best_r         <= bop_pkg::INIT_OFFSET;
      leader_r       <= bop_pkg::INIT_OFFSET;
      leader_score_r <= '0;
      round_r        <= '0;
      for (int i = 1; i < num_offsets_lp; i++) scores_r[i] <= '0;
    end else begin
      state_r       <= state_n;
      test_offset_r <= test_offset_n;
      if (win) begin
        // Max score adopts the offset at once and restarts the rounds
        best_r         <= test_offset_r;
        leader_r       <= bop_pkg::INIT_OFFSET;
        leader_score_r <= '0;
        round_r        <= '0;
        for (int i = 1; i < num_offsets_lp; i++) scores_r[i] <= '0;
      end else if (round_end) begin
        best_r <= (leader_score_n > cfg_i.min_score) ? leader_n : bop_pkg::INIT_OFFSET;
        leader_r       <= bop_pkg::INIT_OFFSET;
        leader_score_r <= '0;
        round_r        <= '0;
        for (int i = 1; i < num_offsets_lp; i++) scores_r[i] <= '0;
      end else begin
        if (hit) scores_r[test_offset_r] <= score_inc;
        leader_r       <= leader_n;
        leader_score_r <= leader_score_n;
        if (pop_o) round_r <= round_r + 1'b1;
      end
    end
  end

  assign offset_o = best_r;

endmodule

/* hw/bop_prefetch_issue.sv */
// --------------------
// Prefetch address generation with page-cross check
// --------------------

`timescale 1ns/100ps

module bop_prefetch_issue (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                miss_v_i,
  input  bop_pkg::blk_addr_t  miss_addr_i,
  input  bop_pkg::offset_t    offset_i,
  input  bop_pkg::cfg_t       cfg_i,
  output logic                pf_v_o,
  output bop_pkg::blk_addr_t  pf_addr_o
);

  bop_pkg::blk_addr_t sum;
  logic               same_page;
  logic               pf_v_r;
  bop_pkg::blk_addr_t pf_addr_r;

  assign sum = miss_addr_i + bop_pkg::blk_addr_t'(offset_i);

  // Page number bits must not change
  assign same_page = (sum[bop_pkg::BLK_ADDR_W-1:bop_pkg::PAGE_BLK_BITS] ==
                      miss_addr_i[bop_pkg::BLK_ADDR_W-1:bop_pkg::PAGE_BLK_BITS]);

  always_ff @(posedge clk_i) begin
    if (reset_i) pf_v_r <= 1'b0;
    else pf_v_r <= miss_v_i & cfg_i.enable & same_page;
  end

  always_ff @(posedge clk_i) begin
    if (miss_v_i) pf_addr_r <= sum;
  end

  assign pf_v_o    = pf_v_r;
  assign pf_addr_o = pf_addr_r;

endmodule

/* hw/bop_top.sv */
// --------------------
// Best-offset prefetcher top level
// Config registers beside the queue, history, scorer and issue path
// --------------------

`timescale 1ns/100ps

module bop_top #(
  parameter int history_len_p = 8,
  parameter int max_score_p   = 4,
  parameter int max_rounds_p  = 3
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                miss_v_i,
  input  bop_pkg::blk_addr_t  miss_addr_i,
  output logic                miss_ready_o,
  input  logic                fill_v_i,
  input  bop_pkg::blk_addr_t  fill_addr_i,
  input  logic                cfg_we_i,
  input  bop_pkg::cfg_sel_e   cfg_sel_i,
  input  bop_pkg::score_t     cfg_data_i,
  output logic                pf_v_o,
  output bop_pkg::blk_addr_t  pf_addr_o,
  output bop_pkg::offset_t    offset_o
);

  bop_pkg::cfg_t      cfg;
  logic               miss_accept;
  logic               head_v;
  bop_pkg::blk_addr_t head_addr;
  logic               pop;
  logic               test_v;
  bop_pkg::blk_addr_t test_addr;
  logic               match;

  // Misses offered while the queue is full are dropped
  assign miss_accept = miss_v_i & miss_ready_o;

  bop_config_regs config_regs_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_sel_i  (cfg_sel_i),
    .cfg_data_i (cfg_data_i),
    .cfg_o      (cfg)
  );

  bop_miss_queue miss_queue_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (miss_accept),
    .push_addr_i (miss_addr_i),
    .ready_o     (miss_ready_o),
    .head_v_o    (head_v),
    .head_addr_o (head_addr),
    .pop_i       (pop)
  );

  bop_history_cam #(
    .history_len_p (history_len_p)
  ) history_cam_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_v_i    (fill_v_i),
    .fill_addr_i (fill_addr_i),
    .test_v_i    (test_v),
    .test_addr_i (test_addr),
    .match_o     (match)
  );

  bop_offset_scorer #(
    .max_score_p  (max_score_p),
    .max_rounds_p (max_rounds_p)
  ) offset_scorer_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .head_v_i    (head_v),
    .head_addr_i (head_addr),
    .pop_o       (pop),
    .test_v_o    (test_v),
    .test_addr_o (test_addr),
    .match_i     (match),
    .cfg_i       (cfg),
    .offset_o    (offset_o)
  );

  bop_prefetch_issue prefetch_issue_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_v_i    (miss_accept),
    .miss_addr_i (miss_addr_i),
    .offset_i    (offset_o),
    .cfg_i       (cfg),
    .pf_v_o      (pf_v_o),
    .pf_addr_o   (pf_addr_o)
  );

endmodule

/* sim/bop_props.sv */
// --------------------
// Concurrent assertions on the prefetcher top level
// Queue back-pressure, prefetch pulse and offset range
// --------------------

`timescale 1ns/100ps

module bop_props (
  input logic             clk_i,
  input logic             reset_i,
  input logic             miss_accept_i,
  input logic             pop_i,
  input logic             miss_ready_i,
  input logic             pf_v_i,
  input bop_pkg::offset_t offset_i
);

  // Shadow count of queued misses
  logic [1:0] queued_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) queued_r <= '0;
    else queued_r <= queued_r + 2'(miss_accept_i) - 2'(pop_i);
  end

  ready_low_only_full: assert property (
    @(posedge clk_i) disable iff (reset_i) !miss_ready_i |-> (queued_r == 2'd2)
  ) else $error("miss_ready_o low with %0d entries queued", queued_r);

  pf_after_accept: assert property (
    @(posedge clk_i) disable iff (reset_i) pf_v_i |-> $past(miss_accept_i)
  ) else $error("pf_v_o high without an accepted miss one cycle earlier");

  pf_single_cycle: assert property (
    @(posedge clk_i) disable iff (reset_i) (pf_v_i && !miss_accept_i) |=> !pf_v_i
  ) else $error("pf_v_o held for more than one cycle");

  offset_nonzero: assert property (
    @(posedge clk_i) disable iff (reset_i) offset_i != '0
  ) else $error("offset_o is zero");

endmodule

bind bop_top bop_props props_inst (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .miss_accept_i (miss_accept),
  .pop_i         (pop),
  .miss_ready_i  (miss_ready_o),
  .pf_v_i        (pf_v_o),
  .offset_i      (offset_o)
);

/* sim/tb_bop.sv */
// --------------------
// Testbench for the best-offset prefetcher
// Directed tests, value checks, timeout and closing report
// --------------------

`timescale 1ns/100ps

module tb_bop;

  localparam int drive_dly_lp   = 10;
  localparam int idle_gap_lp    = 20;
  localparam int ready_wait_lp  = 50;
  // Tests need roughly 550 cycles including resets
  localparam int cycle_limit_lp = 2000;

  logic               clk_i;
  logic               reset_i;
  logic               miss_v_i;
  bop_pkg::blk_addr_t miss_addr_i;
  logic               miss_ready_o;
  logic               fill_v_i;
  bop_pkg::blk_addr_t fill_addr_i;
  logic               cfg_we_i;
  bop_pkg::cfg_sel_e  cfg_sel_i;
  bop_pkg::score_t    cfg_data_i;
  logic               pf_v_o;
  bop_pkg::blk_addr_t pf_addr_o;
  bop_pkg::offset_t   offset_o;

  integer seed;
  int     errors;
  int     checks;
  int     cycles = 0;

  bop_top bop_top_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_v_i     (miss_v_i),
    .miss_addr_i  (miss_addr_i),
    .miss_ready_o (miss_ready_o),
    .fill_v_i     (fill_v_i),
    .fill_addr_i  (fill_addr_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_data_i   (cfg_data_i),
    .pf_v_o       (pf_v_o),
    .pf_addr_o    (pf_addr_o),
    .offset_o     (offset_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit_lp) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Inputs change a short delay after each rising edge
  task automatic step();
    @(posedge clk_i);
    #drive_dly_lp;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #drive_dly_lp;
    reset_i = 1'b0;
  endtask

  task automatic write_cfg(input bop_pkg::cfg_sel_e sel, input bop_pkg::score_t data);
    cfg_we_i   = 1'b1;
    cfg_sel_i  = sel;
    cfg_data_i = data;
    step();
    cfg_we_i = 1'b0;
  endtask

  task automatic fill_history(input bop_pkg::blk_addr_t addr);
    fill_v_i    = 1'b1;
    fill_addr_i = addr;
    step();
    fill_v_i = 1'b0;
  endtask

  // Returns one cycle after acceptance, where the prefetch pulse shows
  task automatic send_miss(input bop_pkg::blk_addr_t addr);
    int waited;
    waited = 0;
    while (!miss_ready_o && waited < ready_wait_lp) begin
      step();
      waited++;
    end
    if (!miss_ready_o) begin
      errors++;
      $display("Error at %0t: miss_ready_o stayed low for %0d cycles", $time, waited);
    end
    miss_v_i    = 1'b1;
    miss_addr_i = addr;
    step();
    miss_v_i = 1'b0;
  endtask

  // Block index 0 to 39 keeps addr plus 15 inside the page
  task automatic pick_addr(output bop_pkg::blk_addr_t addr);
    addr      = bop_pkg::blk_addr_t'($random(seed));
    addr[5:0] = addr[5:0] % 6'd40;
  endtask

  task automatic reset_defaults();
    bop_pkg::blk_addr_t a;
    apply_reset();
    expect_equal("offset_o", offset_o, 1);
    expect_equal("pf_v_o", pf_v_o, 0);
    expect_equal("miss_ready_o", miss_ready_o, 1);
    pick_addr(a);
    send_miss(a);
    expect_equal("pf_v_o", pf_v_o, 0);
    step();
    expect_equal("pf_v_o", pf_v_o, 0);
    idle(idle_gap_lp);
  endtask

  task automatic issue_and_page_cross();
    bop_pkg::blk_addr_t a;
    apply_reset();
    write_cfg(bop_pkg::CFG_ENABLE, 1);
    pick_addr(a);
    send_miss(a);
    expect_equal("pf_v_o", pf_v_o, 1);
    expect_equal("pf_addr_o", pf_addr_o, a + 26'd1);
    step();
    expect_equal("pf_v_o", pf_v_o, 0);
    idle(idle_gap_lp);
    // Miss at the last block of a page crosses into the next page
    pick_addr(a);
    a[5:0] = 6'd63;
    send_miss(a);
    expect_equal("pf_v_o", pf_v_o, 0);
    idle(idle_gap_lp);
  endtask

  task automatic learn_best_offset();
    bop_pkg::blk_addr_t a;
    bop_pkg::blk_addr_t b;
    apply_reset();
    write_cfg(bop_pkg::CFG_ENABLE, 1);
    pick_addr(a);
    fill_history(a + 26'd5);
    for (int i = 0; i < 4; i++) begin
      send_miss(a);
      idle(idle_gap_lp);
      // Two misses are short of a decision
      if (i == 1) expect_equal("offset_o", offset_o, 1);
    end
    expect_equal("offset_o", offset_o, 5);
    pick_addr(b);
    send_miss(b);
    expect_equal("pf_v_o", pf_v_o, 1);
    expect_equal("pf_addr_o", pf_addr_o, b + 26'd5);
    idle(idle_gap_lp);
  endtask

  task automatic decide_after_rounds();
    bop_pkg::blk_addr_t x;
    apply_reset();
    pick_addr(x);
    fill_history(x + 26'd3);
    repeat (3) begin
      send_miss(x);
      idle(idle_gap_lp);
    end
    // Score 3 beats the reset minimum of 1
    expect_equal("offset_o", offset_o, 3);
    write_cfg(bop_pkg::CFG_MIN_SCORE, 3);
    repeat (3) begin
      send_miss(x);
      idle(idle_gap_lp);
    end
    expect_equal("offset_o", offset_o, 1);
  endtask

  task automatic drop_when_full();
    bop_pkg::blk_addr_t a0;
    bop_pkg::blk_addr_t a1;
    bop_pkg::blk_addr_t a2;
    int pulses;
    apply_reset();
    write_cfg(bop_pkg::CFG_ENABLE, 1);
    pick_addr(a0);
    pick_addr(a1);
    pick_addr(a2);
    pulses      = 0;
    miss_v_i    = 1'b1;
    miss_addr_i = a0;
    expect_equal("miss_ready_o", miss_ready_o, 1);
    step();
    pulses += pf_v_o;
    expect_equal("pf_addr_o", pf_addr_o, a0 + 26'd1);
    miss_addr_i = a1;
    expect_equal("miss_ready_o", miss_ready_o, 1);
    step();
    pulses += pf_v_o;
    expect_equal("pf_addr_o", pf_addr_o, a1 + 26'd1);
    // Two queued entries block the third miss
    miss_addr_i = a2;
    expect_equal("miss_ready_o", miss_ready_o, 0);
    step();
    pulses += pf_v_o;
    miss_v_i = 1'b0;
    repeat (idle_gap_lp) begin
      step();
      pulses += pf_v_o;
    end
    expect_equal("pf_v_o pulse count", pulses, 2);
    expect_equal("miss_ready_o", miss_ready_o, 1);
    idle(idle_gap_lp);
  endtask

  task automatic evict_oldest_fill();
    bop_pkg::blk_addr_t y;
    apply_reset();
    pick_addr(y);
    fill_history(y + 26'd3);
    // Eight more fills far outside the tested range push out the first
    for (int i = 1; i <= 8; i++) fill_history(y + 26'(64 * i));
    for (int i = 0; i < 8; i++) begin
      send_miss(y);
      idle(idle_gap_lp);
      expect_equal("offset_o", offset_o, 1);
    end
  endtask

  initial begin
    seed        = 32'h6a96;
    errors      = 0;
    checks      = 0;
    reset_i     = 1'b1;
    miss_v_i    = 1'b0;
    miss_addr_i = '0;
    fill_v_i    = 1'b0;
    fill_addr_i = '0;
    cfg_we_i    = 1'b0;
    cfg_sel_i   = bop_pkg::CFG_ENABLE;
    cfg_data_i  = '0;
    reset_defaults();
    issue_and_page_cross();
    learn_best_offset();
    decide_after_rounds();
    drop_when_full();
    evict_oldest_fill();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/bop_pkg.sv
hw/bop_config_regs.sv
hw/bop_miss_queue.sv
hw/bop_history_cam.sv
hw/bop_offset_scorer.sv
hw/bop_prefetch_issue.sv
hw/bop_top.sv
sim/bop_props.sv
sim/tb_bop.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the best-offset prefetcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bop -f vlog.f -o sim_bop

out=$(./obj_dir/sim_bop 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
  exit 0
fi
exit 1
